//--- rtl/pinmux_pkg.sv
// Pin-mux peripheral package
// Bus widths, block address map, register indices and bus structs

`default_nettype none

package pinmux_pkg;

   //--------------------------------------------------------------------
   // Widths with a meaning
   //--------------------------------------------------------------------
   typedef logic [8:0]  reg_addr_t;
   typedef logic [3:0]  reg_idx_t;
   typedef logic [2:0]  blk_sel_t;
   typedef logic [31:0] reg_data_t;
   typedef logic [3:0]  reg_be_t;
   typedef logic [31:0] pad_vec_t;
   typedef logic [15:0] timer_cnt_t;

   // Block codes on address bits 8:6, codes 2 and 4-7 unmapped
   localparam blk_sel_t BLK_GLBL  = 3'd0;
   localparam blk_sel_t BLK_GPIO  = 3'd1;
   localparam blk_sel_t BLK_TIMER = 3'd3;

   localparam int NUM_TIMERS = 2;
   // Irq sources: gpio, then one per timer
   localparam int NUM_IRQ = NUM_TIMERS + 1;

   localparam reg_data_t CHIP_ID = 32'h504d_0102;

   // Global block
   localparam reg_idx_t GLBL_ID       = 4'd0;
   localparam reg_idx_t GLBL_IRQ_MASK = 4'd1;
   localparam reg_idx_t GLBL_IRQ_STAT = 4'd2;
   localparam reg_idx_t GLBL_MFSEL    = 4'd3;

   // GPIO block
   localparam reg_idx_t GPIO_DIR      = 4'd0;
   localparam reg_idx_t GPIO_OUT      = 4'd1;
   localparam reg_idx_t GPIO_IN       = 4'd2;
   localparam reg_idx_t GPIO_INT_STAT = 4'd3;
   localparam reg_idx_t GPIO_INT_EN   = 4'd4;

   // Timer block
   localparam reg_idx_t TMR_CFG0 = 4'd0;
   localparam reg_idx_t TMR_CFG1 = 4'd1;
   localparam reg_idx_t TMR_STAT = 4'd2;

   localparam int TMR_EN_BIT = 16;
   // Reload in 15:0 plus the enable bit, rest reads zero
   localparam reg_data_t TMR_CFG_MASK = 32'h0001_ffff;

   //--------------------------------------------------------------------
   // Register bus
   //--------------------------------------------------------------------
   typedef struct packed {
      logic      cs;
      logic      wr;
      reg_idx_t  idx;
      reg_data_t wdata;
      reg_be_t   be;
   } reg_req_t;

   typedef struct packed {
      logic      ack;
      reg_data_t rdata;
   } reg_rsp_t;

   // Byte lanes selected by a byte enable, as a bit mask
   function automatic reg_data_t be_mask(reg_be_t be);
      reg_data_t mask;
      for (int b = 0; b < $bits(reg_be_t); b++) begin
         mask[8*b +: 8] = {8{be[b]}};
      end
      return mask;
   endfunction

   // Old value with the enabled bytes replaced
   function automatic reg_data_t apply_be(reg_data_t old_val, reg_data_t new_val, reg_be_t be);
      reg_data_t mask;
      mask = be_mask(be);
      return (old_val & ~mask) | (new_val & mask);
   endfunction

endpackage

`default_nettype wire

//--- rtl/reg_decode.sv
// Register bus decoder
// Fans the request out by block and returns one response

`default_nettype none
`timescale 1ns/100ps

module reg_decode (
   input  logic                  mclk_i,
   input  logic                  rst_i,
   input  logic                  reg_cs_i,
   input  logic                  reg_wr_i,
   input  pinmux_pkg::reg_addr_t reg_addr_i,
   input  pinmux_pkg::reg_data_t reg_wdata_i,
   input  pinmux_pkg::reg_be_t   reg_be_i,
   output pinmux_pkg::reg_req_t  glbl_req_o,
   output pinmux_pkg::reg_req_t  gpio_req_o,
   output pinmux_pkg::reg_req_t  tmr_req_o,
   input  pinmux_pkg::reg_rsp_t  glbl_rsp_i,
   input  pinmux_pkg::reg_rsp_t  gpio_rsp_i,
   input  pinmux_pkg::reg_rsp_t  tmr_rsp_i,
   output pinmux_pkg::reg_data_t reg_rdata_o,
   output logic                  reg_ack_o
);
   import pinmux_pkg::*;

   blk_sel_t blk_sel;
   reg_req_t req_base;
   logic     unmap_cs;
   logic     unmap_ack_q;
   reg_rsp_t rsp_sel;

   // Block on bits 8:6, word index on bits 5:2
   assign blk_sel  = reg_addr_i[8:6];
   assign req_base = '{cs: reg_cs_i, wr: reg_wr_i, idx: reg_addr_i[5:2],
                       wdata: reg_wdata_i, be: reg_be_i};

   // Only the addressed block sees cs
   always_comb begin
      glbl_req_o    = req_base;
      gpio_req_o    = req_base;
      tmr_req_o     = req_base;
      glbl_req_o.cs = reg_cs_i && (blk_sel == BLK_GLBL);
      gpio_req_o.cs = reg_cs_i && (blk_sel == BLK_GPIO);
      tmr_req_o.cs  = reg_cs_i && (blk_sel == BLK_TIMER);
   end

   //--------------------------------------------------------------------
   // Unmapped blocks still answer, so the bus cannot hang
   //--------------------------------------------------------------------
   assign unmap_cs = reg_cs_i && !(blk_sel inside {BLK_GLBL, BLK_GPIO, BLK_TIMER});

   always_ff @(posedge mclk_i) begin
      if (rst_i) begin
         unmap_ack_q <= 1'b0;
      end else begin
         unmap_ack_q <= unmap_cs && !unmap_ack_q;
      end
   end

   // Response mux, address is held until ack
   always_comb begin
      case (blk_sel)
         BLK_GLBL:  rsp_sel = glbl_rsp_i;
         BLK_GPIO:  rsp_sel = gpio_rsp_i;
         BLK_TIMER: rsp_sel = tmr_rsp_i;
         default:   rsp_sel = '{ack: unmap_ack_q, rdata: '0};
      endcase
   end

   assign reg_ack_o   = rsp_sel.ack;
   assign reg_rdata_o = rsp_sel.rdata;

   // Any block's ack must answer a live request
   ack_needs_cs: assert property (@(posedge mclk_i) disable iff (rst_i)
      $rose(reg_ack_o) |-> reg_cs_i);

endmodule

`default_nettype wire

//--- rtl/glbl_reg.sv
// Global register block
// Chip id, interrupt mask and raw status, multi-function select

`default_nettype none
`timescale 1ns/100ps

module glbl_reg (
   input  logic                                 mclk_i,
   input  logic                                 rst_i,
   input  pinmux_pkg::reg_req_t                 req_i,
   output pinmux_pkg::reg_rsp_t                 rsp_o,
   input  logic                                 gpio_intr_i,
   input  logic [pinmux_pkg::NUM_TIMERS-1:0]    timer_intr_i,
   output pinmux_pkg::pad_vec_t                 mfsel_o,
   output logic                                 irq_o
);
   import pinmux_pkg::*;

   logic               ack_q;
   reg_data_t          rdata_q;
   reg_data_t          rdata_nxt;
   logic               wr_en;
   logic [NUM_IRQ-1:0] irq_mask_q;
   logic [NUM_IRQ-1:0] irq_stat;
   reg_data_t          mask_merged;
   pad_vec_t           mfsel_q;

   // Write lands on the acknowledge edge
   assign wr_en = req_i.cs && req_i.wr && !ack_q;

   // Raw status with gpio in bit 0 and the timers above it
   assign irq_stat = {timer_intr_i, gpio_intr_i};
   assign irq_o    = |(irq_stat & irq_mask_q);

   assign mask_merged = apply_be(reg_data_t'(irq_mask_q), req_i.wdata, req_i.be);

   //--------------------------------------------------------------------
   // Read mux
   //--------------------------------------------------------------------
   always_comb begin
      case (req_i.idx)
         GLBL_ID:       rdata_nxt = CHIP_ID;
         GLBL_IRQ_MASK: rdata_nxt = reg_data_t'(irq_mask_q);
         GLBL_IRQ_STAT: rdata_nxt = reg_data_t'(irq_stat);
         GLBL_MFSEL:    rdata_nxt = mfsel_q;
         default:       rdata_nxt = '0;
      endcase
   end

   // Control state
   always_ff @(posedge mclk_i) begin
      if (rst_i) begin
         ack_q      <= 1'b0;
         irq_mask_q <= '0;
         mfsel_q    <= '0;
      end else begin
         ack_q <= req_i.cs && !ack_q;
         if (wr_en && req_i.idx == GLBL_IRQ_MASK) begin
            irq_mask_q <= mask_merged[NUM_IRQ-1:0];
         end
         if (wr_en && req_i.idx == GLBL_MFSEL) begin
            mfsel_q <= apply_be(mfsel_q, req_i.wdata, req_i.be);
         end
      end
   end

   // Read data captured with the ack
   always_ff @(posedge mclk_i) begin
      if (req_i.cs && !ack_q) begin
         rdata_q <= rdata_nxt;
      end
   end

   assign rsp_o   = '{ack: ack_q, rdata: rdata_q};
   assign mfsel_o = mfsel_q;

   // Master drops cs after the ack so one access sees a single ack
   cs_drop_after_ack: assert property (@(posedge mclk_i) disable iff (rst_i)
      rsp_o.ack |=> !req_i.cs);

endmodule

`default_nettype wire

//--- rtl/gpio_regs.sv
// GPIO register block
// Direction, output data, synchronised input and rising-edge interrupts

`default_nettype none
`timescale 1ns/100ps

module gpio_regs (
   input  logic                 mclk_i,
   input  logic                 rst_i,
   input  pinmux_pkg::reg_req_t req_i,
   output pinmux_pkg::reg_rsp_t rsp_o,
   input  pinmux_pkg::pad_vec_t pad_in_i,
   output pinmux_pkg::pad_vec_t gpio_dir_o,
   output pinmux_pkg::pad_vec_t gpio_out_o,
   output logic                 gpio_intr_o
);
   import pinmux_pkg::*;

   logic      ack_q;
   reg_data_t rdata_q;
   reg_data_t rdata_nxt;
   logic      wr_en;
   pad_vec_t  dir_q;
   pad_vec_t  out_q;
   pad_vec_t  int_en_q;
   pad_vec_t  int_stat_q;
   pad_vec_t  in_meta_q;
   pad_vec_t  in_sync_q;
   pad_vec_t  in_prev_q;
   pad_vec_t  rise;
   pad_vec_t  stat_clr;

   assign wr_en = req_i.cs && req_i.wr && !ack_q;

   // Enabled rising edges of the synchronised input
   assign rise = in_sync_q & ~in_prev_q & int_en_q;

   // Write one to clear, only on enabled bytes
   assign stat_clr = (wr_en && req_i.idx == GPIO_INT_STAT) ?
                     (req_i.wdata & be_mask(req_i.be)) : '0;

   //--------------------------------------------------------------------
   // Read mux
   //--------------------------------------------------------------------
   always_comb begin
      case (req_i.idx)
         GPIO_DIR:      rdata_nxt = dir_q;
         GPIO_OUT:      rdata_nxt = out_q;
         GPIO_IN:       rdata_nxt = in_sync_q;
         GPIO_INT_STAT: rdata_nxt = int_stat_q;
         GPIO_INT_EN:   rdata_nxt = int_en_q;
         default:       rdata_nxt = '0;
      endcase
   end

   always_ff @(posedge mclk_i) begin
      if (rst_i) begin
         ack_q      <= 1'b0;
         dir_q      <= '0;
         out_q      <= '0;
         int_en_q   <= '0;
         int_stat_q <= '0;
         in_meta_q  <= '0;
         in_sync_q  <= '0;
         in_prev_q  <= '0;
      end else begin
         ack_q <= req_i.cs && !ack_q;
         // Two-stage sync, then edge history
         in_meta_q <= pad_in_i;
         in_sync_q <= in_meta_q;
         in_prev_q <= in_sync_q;
         if (wr_en && req_i.idx == GPIO_DIR) begin
            dir_q <= apply_be(dir_q, req_i.wdata, req_i.be);
         end
         if (wr_en && req_i.idx == GPIO_OUT) begin
            out_q <= apply_be(out_q, req_i.wdata, req_i.be);
         end
         if (wr_en && req_i.idx == GPIO_INT_EN) begin
            int_en_q <= apply_be(int_en_q, req_i.wdata, req_i.be);
         end
         // New edge wins over a clear in the same cycle
         int_stat_q <= (int_stat_q & ~stat_clr) | rise;
      end
   end

   always_ff @(posedge mclk_i) begin
      if (req_i.cs && !ack_q) begin
         rdata_q <= rdata_nxt;
      end
   end

   assign rsp_o       = '{ack: ack_q, rdata: rdata_q};
   assign gpio_dir_o  = dir_q;
   assign gpio_out_o  = out_q;
   assign gpio_intr_o = |int_stat_q;

endmodule

`default_nettype wire

//--- rtl/timer_regs.sv
// Timer register block
// Two reloadable down-counters with expiry interrupts and waveform toggles

`default_nettype none
`timescale 1ns/100ps

module timer_regs (
   input  logic                              mclk_i,
   input  logic                              rst_i,
   input  pinmux_pkg::reg_req_t              req_i,
   output pinmux_pkg::reg_rsp_t              rsp_o,
   output logic [pinmux_pkg::NUM_TIMERS-1:0] timer_intr_o,
   output logic [pinmux_pkg::NUM_TIMERS-1:0] timer_wfm_o
);
   import pinmux_pkg::*;

   logic                  ack_q;
   reg_data_t             rdata_q;
   reg_data_t             rdata_nxt;
   logic                  wr_en;
   reg_data_t             cfg_q [NUM_TIMERS];
   timer_cnt_t            cnt_q [NUM_TIMERS];
   logic [NUM_TIMERS-1:0] run_q;
   logic [NUM_TIMERS-1:0] active;
   logic [NUM_TIMERS-1:0] expire;
   logic [NUM_TIMERS-1:0] stat_q;
   logic [NUM_TIMERS-1:0] wfm_q;
   reg_data_t             stat_clr;

   assign wr_en    = req_i.cs && req_i.wr && !ack_q;
   assign stat_clr = (wr_en && req_i.idx == TMR_STAT) ?
                     (req_i.wdata & be_mask(req_i.be)) : '0;

   // run_q delays start one cycle so the new reload is loaded first
   always_comb begin
      for (int t = 0; t < NUM_TIMERS; t++) begin
         active[t] = run_q[t] && cfg_q[t][TMR_EN_BIT];
         expire[t] = active[t] && (cnt_q[t] == '0);
      end
   end

   always_comb begin
      case (req_i.idx)
         TMR_CFG0: rdata_nxt = cfg_q[0];
         TMR_CFG1: rdata_nxt = cfg_q[1];
         TMR_STAT: rdata_nxt = reg_data_t'(stat_q);
         default:  rdata_nxt = '0;
      endcase
   end

   //--------------------------------------------------------------------
   // Config, counters and status
   //--------------------------------------------------------------------
   always_ff @(posedge mclk_i) begin
      if (rst_i) begin
         ack_q  <= 1'b0;
         run_q  <= '0;
         stat_q <= '0;
         wfm_q  <= '0;
         for (int t = 0; t < NUM_TIMERS; t++) begin
            cfg_q[t] <= '0;
            cnt_q[t] <= '0;
         end
      end else begin
         ack_q <= req_i.cs && !ack_q;
         for (int t = 0; t < NUM_TIMERS; t++) begin
            if (wr_en && req_i.idx == reg_idx_t'(TMR_CFG0 + t)) begin
               cfg_q[t] <= apply_be(cfg_q[t], req_i.wdata, req_i.be) & TMR_CFG_MASK;
            end
            run_q[t] <= cfg_q[t][TMR_EN_BIT];
            // Idle or expired: sit at reload
            if (!active[t] || expire[t]) begin
               cnt_q[t] <= cfg_q[t][15:0];
            end else begin
               cnt_q[t] <= cnt_q[t] - 1'b1;
            end
            if (expire[t]) begin
               wfm_q[t] <= ~wfm_q[t];
            end
         end
         stat_q <= (stat_q & ~stat_clr[NUM_TIMERS-1:0]) | expire;
      end
   end

   always_ff @(posedge mclk_i) begin
      if (req_i.cs && !ack_q) begin
         rdata_q <= rdata_nxt;
      end
   end

   assign rsp_o        = '{ack: ack_q, rdata: rdata_q};
   assign timer_intr_o = stat_q;
   assign timer_wfm_o  = wfm_q;

endmodule

`default_nettype wire

//--- rtl/pad_mux.sv
// Digital pad mux
// GPIO or timer waveform per pad, active-low output enables

`default_nettype none
`timescale 1ns/100ps

module pad_mux (
   input  pinmux_pkg::pad_vec_t              gpio_dir_i,
   input  pinmux_pkg::pad_vec_t              gpio_out_i,
   input  pinmux_pkg::pad_vec_t              mfsel_i,
   input  logic [pinmux_pkg::NUM_TIMERS-1:0] timer_wfm_i,
   input  pinmux_pkg::pad_vec_t              digital_io_in_i,
   output pinmux_pkg::pad_vec_t              digital_io_out_o,
   output pinmux_pkg::pad_vec_t              digital_io_oen_o,
   output pinmux_pkg::pad_vec_t              pad_in_o
);
   import pinmux_pkg::*;

   //--------------------------------------------------------------------
   // Output path
   //--------------------------------------------------------------------
   always_comb begin
      // Default GPIO, dir 1 means driven so oen is low
      digital_io_out_o = gpio_out_i;
      digital_io_oen_o = ~gpio_dir_i;
      // Pad t carries timer t waveform when selected
      for (int t = 0; t < NUM_TIMERS; t++) begin
         if (mfsel_i[t]) begin
            digital_io_out_o[t] = timer_wfm_i[t];
            digital_io_oen_o[t] = 1'b0;
         end
      end
   end

   // Inputs go straight back to GPIO
   assign pad_in_o = digital_io_in_i;

endmodule

`default_nettype wire

//--- rtl/pinmux_top.sv
// Pin-mux peripheral top
// Register decoder, global, GPIO and timer blocks, pad mux

`default_nettype none
`timescale 1ns/100ps

module pinmux_top (
   input  logic                  mclk_i,
   input  logic                  rst_i,
   input  logic                  reg_cs_i,
   input  logic                  reg_wr_i,
   input  pinmux_pkg::reg_addr_t reg_addr_i,
   input  pinmux_pkg::reg_data_t reg_wdata_i,
   input  pinmux_pkg::reg_be_t   reg_be_i,
   output pinmux_pkg::reg_data_t reg_rdata_o,
   output logic                  reg_ack_o,
   output logic                  irq_o,
   input  pinmux_pkg::pad_vec_t  digital_io_in_i,
   output pinmux_pkg::pad_vec_t  digital_io_out_o,
   output pinmux_pkg::pad_vec_t  digital_io_oen_o
);
   import pinmux_pkg::*;

   reg_req_t              glbl_req;
   reg_req_t              gpio_req;
   reg_req_t              tmr_req;
   reg_rsp_t              glbl_rsp;
   reg_rsp_t              gpio_rsp;
   reg_rsp_t              tmr_rsp;
   logic                  gpio_intr;
   logic [NUM_TIMERS-1:0] timer_intr;
   logic [NUM_TIMERS-1:0] timer_wfm;
   pad_vec_t              mfsel;
   pad_vec_t              gpio_dir;
   pad_vec_t              gpio_out;
   pad_vec_t              pad_in;

   reg_decode u_reg_decode (
      .mclk_i      (mclk_i),
      .rst_i       (rst_i),
      .reg_cs_i    (reg_cs_i),
      .reg_wr_i    (reg_wr_i),
      .reg_addr_i  (reg_addr_i),
      .reg_wdata_i (reg_wdata_i),
      .reg_be_i    (reg_be_i),
      .glbl_req_o  (glbl_req),
      .gpio_req_o  (gpio_req),
      .tmr_req_o   (tmr_req),
      .glbl_rsp_i  (glbl_rsp),
      .gpio_rsp_i  (gpio_rsp),
      .tmr_rsp_i   (tmr_rsp),
      .reg_rdata_o (reg_rdata_o),
      .reg_ack_o   (reg_ack_o)
   );

   glbl_reg u_glbl_reg (
      .mclk_i       (mclk_i),
      .rst_i        (rst_i),
      .req_i        (glbl_req),
      .rsp_o        (glbl_rsp),
      .gpio_intr_i  (gpio_intr),
      .timer_intr_i (timer_intr),
      .mfsel_o      (mfsel),
      .irq_o        (irq_o)
   );

   gpio_regs u_gpio_regs (
      .mclk_i      (mclk_i),
      .rst_i       (rst_i),
      .req_i       (gpio_req),
      .rsp_o       (gpio_rsp),
      .pad_in_i    (pad_in),
      .gpio_dir_o  (gpio_dir),
      .gpio_out_o  (gpio_out),
      .gpio_intr_o (gpio_intr)
   );

   timer_regs u_timer_regs (
      .mclk_i       (mclk_i),
      .rst_i        (rst_i),
      .req_i        (tmr_req),
      .rsp_o        (tmr_rsp),
      .timer_intr_o (timer_intr),
      .timer_wfm_o  (timer_wfm)
   );

   pad_mux u_pad_mux (
      .gpio_dir_i       (gpio_dir),
      .gpio_out_i       (gpio_out),
      .mfsel_i          (mfsel),
      .timer_wfm_i      (timer_wfm),
      .digital_io_in_i  (digital_io_in_i),
      .digital_io_out_o (digital_io_out_o),
      .digital_io_oen_o (digital_io_oen_o),
      .pad_in_o         (pad_in)
   );

endmodule

`default_nettype wire

//--- verification/tb_clkgen.sv
// Testbench clock and reset generator
// Free-running clock, reset held high for the first cycles

`default_nettype none
`timescale 1ns/100ps

module tb_clkgen #(
   parameter int PERIOD_NS    = 4,
   parameter int RESET_CYCLES = 3
) (
   output logic mclk_o,
   output logic rst_o
);

   initial begin
      mclk_o = 1'b0;
      forever begin
         #(PERIOD_NS / 2) mclk_o = ~mclk_o;
      end
   end

   // Released on a rising edge, like any other stimulus
   initial begin
      rst_o <= 1'b1;
      repeat (RESET_CYCLES) @(posedge mclk_o);
      rst_o <= 1'b0;
   end

endmodule

`default_nettype wire

//--- verification/pinmux_tb.sv
// Pin-mux peripheral testbench
// Directed tests over the register bus and the digital pads

`default_nettype none
`timescale 1ns/100ps

module pinmux_tb;
   import pinmux_pkg::*;

   localparam int CLK_PERIOD_NS   = 4;
   localparam int ACK_LIMIT       = 8;
   // Cycle budget per test in run order
   localparam int TEST_CYCLES     = 40 + 90 + 80 + 90 + 80;
   localparam int WATCHDOG_MARGIN = 4;
   localparam int WATCHDOG_NS     = TEST_CYCLES * WATCHDOG_MARGIN * CLK_PERIOD_NS;

   logic        mclk;
   logic        rst;
   logic        reg_cs;
   logic        reg_wr;
   reg_addr_t   reg_addr;
   reg_data_t   reg_wdata;
   reg_be_t     reg_be;
   reg_data_t   reg_rdata;
   logic        reg_ack;
   logic        irq;
   pad_vec_t    pad_in;
   pad_vec_t    pad_out;
   pad_vec_t    pad_oen;

   int          mismatch_cnt;
   int          other_err_cnt;
   logic [31:0] lcg_state;

   // Shadow copies of the writable registers
   reg_data_t   dir_exp;
   reg_data_t   out_exp;
   reg_data_t   mask_exp;

   tb_clkgen #(.PERIOD_NS(CLK_PERIOD_NS), .RESET_CYCLES(3)) u_clkgen (
      .mclk_o (mclk),
      .rst_o  (rst)
   );

   pinmux_top dut (
      .mclk_i           (mclk),
      .rst_i            (rst),
      .reg_cs_i         (reg_cs),
      .reg_wr_i         (reg_wr),
      .reg_addr_i       (reg_addr),
      .reg_wdata_i      (reg_wdata),
      .reg_be_i         (reg_be),
      .reg_rdata_o      (reg_rdata),
      .reg_ack_o        (reg_ack),
      .irq_o            (irq),
      .digital_io_in_i  (pad_in),
      .digital_io_out_o (pad_out),
      .digital_io_oen_o (pad_oen)
   );

   //--------------------------------------------------------------------
   // Helpers
   //--------------------------------------------------------------------
   function automatic reg_data_t next_rand();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // Block on bits 8:6 and word index on bits 5:2
   function automatic reg_addr_t make_addr(blk_sel_t blk, reg_idx_t idx);
      return {blk, idx, 2'b00};
   endfunction

   // Expected register after a byte-enabled write
   function automatic reg_data_t merge_bytes(reg_data_t old_val, reg_data_t new_val,
                                             reg_be_t be);
      reg_data_t res;
      res = old_val;
      for (int b = 0; b < 4; b++) begin
         if (be[b]) begin
            res[8*b +: 8] = new_val[8*b +: 8];
         end
      end
      return res;
   endfunction

   task automatic check_data(input string what, input reg_data_t got, input reg_data_t exp);
      if (got !== exp) begin
         mismatch_cnt++;
         $display("mismatch %s: got %h, expected %h", what, got, exp);
      end
   endtask

   task automatic check_pads(input string what, input pad_vec_t got, input pad_vec_t exp);
      if (got !== exp) begin
         mismatch_cnt++;
         $display("mismatch %s: got %h, expected %h", what, got, exp);
      end
   endtask

   task automatic check_bit(input string what, input logic got, input logic exp);
      if (got !== exp) begin
         mismatch_cnt++;
         $display("mismatch %s: got %h, expected %h", what, got, exp);
      end
   endtask

   // One access with the request held until ack and cs dropped after
   task automatic bus_cycle(input logic wr, input reg_addr_t addr, input reg_data_t wdata,
                            input reg_be_t be, output reg_data_t rdata);
      int waited;
      @(posedge mclk);
      reg_cs    <= 1'b1;
      reg_wr    <= wr;
      reg_addr  <= addr;
      reg_wdata <= wdata;
      reg_be    <= be;
      waited = 0;
      rdata  = '0;
      do begin
         @(negedge mclk);
         waited++;
      end while (!reg_ack && waited < ACK_LIMIT);
      if (reg_ack) begin
         rdata = reg_rdata;
      end else begin
         other_err_cnt++;
         $display("no acknowledge within %0d cycles for address %h", ACK_LIMIT, addr);
      end
      @(posedge mclk);
      reg_cs <= 1'b0;
      reg_wr <= 1'b0;
   endtask

   task automatic bus_write(input reg_addr_t addr, input reg_data_t data, input reg_be_t be);
      reg_data_t ignored;
      bus_cycle(1'b1, addr, data, be, ignored);
   endtask

   task automatic bus_read(input reg_addr_t addr, output reg_data_t data);
      bus_cycle(1'b0, addr, '0, 4'hf, data);
   endtask

   //--------------------------------------------------------------------
   // Directed tests
   //--------------------------------------------------------------------
   task automatic reset_values();
      reg_data_t rd;
      @(negedge mclk);
      check_pads("digital_io_oen_o", pad_oen, '1);
      check_pads("digital_io_out_o", pad_out, '0);
      check_bit("irq_o", irq, 1'b0);
      check_bit("reg_ack_o", reg_ack, 1'b0);
      bus_read(make_addr(BLK_GLBL, GLBL_ID), rd);
      check_data("CHIP_ID", rd, CHIP_ID);
      bus_read(make_addr(BLK_GLBL, GLBL_IRQ_STAT), rd);
      check_data("GLBL_IRQ_STAT", rd, '0);
      bus_read(make_addr(BLK_GPIO, GPIO_DIR), rd);
      check_data("GPIO_DIR", rd, '0);
      bus_read(make_addr(BLK_GPIO, GPIO_INT_STAT), rd);
      check_data("GPIO_INT_STAT", rd, '0);
      bus_read(make_addr(BLK_TIMER, TMR_STAT), rd);
      check_data("TMR_STAT", rd, '0);
   endtask

   task automatic gpio_output_path();
      reg_data_t wdata;
      reg_data_t rd;
      reg_data_t rnd;
      reg_be_t   be;
      for (int i = 0; i < 4; i++) begin
         // Full word first and random byte enables after
         rnd = next_rand();
         be = (i == 0) ? 4'hf : rnd[3:0];
         wdata = next_rand();
         bus_write(make_addr(BLK_GPIO, GPIO_DIR), wdata, be);
         dir_exp = merge_bytes(dir_exp, wdata, be);
         rnd = next_rand();
         be = (i == 0) ? 4'hf : rnd[7:4];
         wdata = next_rand();
         bus_write(make_addr(BLK_GPIO, GPIO_OUT), wdata, be);
         out_exp = merge_bytes(out_exp, wdata, be);
         bus_read(make_addr(BLK_GPIO, GPIO_DIR), rd);
         check_data("GPIO_DIR", rd, dir_exp);
         bus_read(make_addr(BLK_GPIO, GPIO_OUT), rd);
         check_data("GPIO_OUT", rd, out_exp);
         @(negedge mclk);
         check_pads("digital_io_out_o", pad_out, out_exp);
         check_pads("digital_io_oen_o", pad_oen, ~dir_exp);
      end
   endtask

   task automatic gpio_input_irq();
      reg_data_t rd;
      pad_vec_t  level;
      pad_vec_t  en;
      pad_vec_t  rise;
      level = next_rand();
      @(posedge mclk);
      pad_in <= level;
      repeat (4) @(posedge mclk);
      bus_read(make_addr(BLK_GPIO, GPIO_IN), rd);
      check_data("GPIO_IN", rd, level);
      // Pads low again before arming the edge detect
      @(posedge mclk);
      pad_in <= '0;
      repeat (4) @(posedge mclk);
      en   = next_rand() | 32'h1;
      rise = next_rand() | 32'h1;
      bus_write(make_addr(BLK_GPIO, GPIO_INT_EN), en, 4'hf);
      mask_exp = 32'h1;
      bus_write(make_addr(BLK_GLBL, GLBL_IRQ_MASK), mask_exp, 4'hf);
      @(posedge mclk);
      pad_in <= rise;
      repeat (4) @(posedge mclk);
      bus_read(make_addr(BLK_GPIO, GPIO_INT_STAT), rd);
      check_data("GPIO_INT_STAT", rd, rise & en);
      @(negedge mclk);
      check_bit("irq_o", irq, 1'b1);
      // Write one to clear every status bit
      bus_write(make_addr(BLK_GPIO, GPIO_INT_STAT), '1, 4'hf);
      bus_read(make_addr(BLK_GPIO, GPIO_INT_STAT), rd);
      check_data("GPIO_INT_STAT", rd, '0);
      @(negedge mclk);
      check_bit("irq_o", irq, 1'b0);
   endtask

   task automatic timer_expiry();
      reg_data_t rd;
      reg_data_t cfg;
      logic      pad0_prev;
      int        changes;
      cfg = (32'h1 << TMR_EN_BIT) | 32'd10;
      bus_write(make_addr(BLK_GLBL, GLBL_MFSEL), 32'h1, 4'hf);
      bus_write(make_addr(BLK_TIMER, TMR_CFG0), cfg, 4'hf);
      changes = 0;
      @(negedge mclk);
      pad0_prev = pad_out[0];
      check_bit("digital_io_oen_o[0]", pad_oen[0], 1'b0);
      repeat (40) begin
         @(negedge mclk);
         if (pad_out[0] !== pad0_prev) begin
            changes++;
         end
         pad0_prev = pad_out[0];
      end
      if (changes == 0) begin
         other_err_cnt++;
         $display("pad 0 never changed while timer 0 was running");
      end
      bus_read(make_addr(BLK_TIMER, TMR_STAT), rd);
      check_bit("TMR_STAT[0]", rd[0], 1'b1);
      check_bit("TMR_STAT[1]", rd[1], 1'b0);
      // Stop timer 0 so a cleared bit stays clear
      bus_write(make_addr(BLK_TIMER, TMR_CFG0), 32'd10, 4'hf);
      bus_write(make_addr(BLK_TIMER, TMR_STAT), 32'h1, 4'hf);
      bus_read(make_addr(BLK_TIMER, TMR_STAT), rd);
      check_data("TMR_STAT", rd, '0);
   endtask

   task automatic unmapped_access();
      reg_data_t rd;
      blk_sel_t  blks [4];
      blks = '{3'd2, 3'd5, 3'd6, 3'd7};
      foreach (blks[k]) begin
         bus_read(make_addr(blks[k], GPIO_DIR), rd);
         check_data($sformatf("block %0d word 0", blks[k]), rd, '0);
         bus_read(make_addr(blks[k], GLBL_IRQ_MASK), rd);
         check_data($sformatf("block %0d word 1", blks[k]), rd, '0);
         // Same word offsets as DIR and IRQ_MASK with every bit flipped
         bus_write(make_addr(blks[k], GPIO_DIR), ~dir_exp, 4'hf);
         bus_write(make_addr(blks[k], GLBL_IRQ_MASK), ~mask_exp, 4'hf);
      end
      bus_read(make_addr(BLK_GPIO, GPIO_DIR), rd);
      check_data("GPIO_DIR", rd, dir_exp);
      bus_read(make_addr(BLK_GLBL, GLBL_IRQ_MASK), rd);
      check_data("GLBL_IRQ_MASK", rd, mask_exp);
   endtask

   //--------------------------------------------------------------------
   // Sequence and summary
   //--------------------------------------------------------------------
   initial begin
      lcg_state     = 32'h092d_8faa;
      mismatch_cnt  = 0;
      other_err_cnt = 0;
      dir_exp       = '0;
      out_exp       = '0;
      mask_exp      = '0;
      reg_cs    <= 1'b0;
      reg_wr    <= 1'b0;
      reg_addr  <= '0;
      reg_wdata <= '0;
      reg_be    <= '0;
      pad_in    <= '0;
      wait (rst === 1'b0);
      @(posedge mclk);
      reset_values();
      gpio_output_path();
      gpio_input_irq();
      timer_expiry();
      unmapped_access();
      $display("summary: %0d mismatches, %0d other errors", mismatch_cnt, other_err_cnt);
      if (mismatch_cnt == 0 && other_err_cnt == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

   // Watchdog
   initial begin
      #(WATCHDOG_NS);
      $display("watchdog expired after %0d ns, tests did not finish", WATCHDOG_NS);
      $display("FAIL: see errors above");
      $finish;
   end

endmodule

`default_nettype wire

//--- list.f
rtl/pinmux_pkg.sv
rtl/reg_decode.sv
rtl/glbl_reg.sv
rtl/gpio_regs.sv
rtl/timer_regs.sv
rtl/pad_mux.sv
rtl/pinmux_top.sv
verification/tb_clkgen.sv
verification/pinmux_tb.sv

//--- Makefile
# Verilator build and run for the pin-mux testbench

VERILATOR ?= verilator
TOP       ?= pinmux_tb
FILE_LIST ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= PASS: all tests
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j 0

.PHONY: help build test clean

help:
	@echo "Targets:"
	@echo "  build  compile $(TOP) with Verilator from $(FILE_LIST)"
	@echo "  test   build, run, and look for the pass line in $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILE_LIST)

test: build
	rm -f $(LOG)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) && echo "test passed" || (echo "test failed"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
